//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_axi_rd_slave
FILELIST  := axi_rd_slave.f
OBJ_DIR   := obj_dir
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- axi_rd_slave.f
design/axi_rd_pkg.sv
design/rr_arbiter.sv
design/burst_addr_gen.sv
design/ost_slot.sv
design/axi_rd_slave.sv
verif/axi_rd_slave_sva.sv
verif/tb_axi_rd_slave.sv

//--- design/axi_rd_pkg.sv
// AXI read slave shared definitions
// Field widths, burst / response / slot state enums, AR and R payload structs

package axi_rd_pkg;

    // -------------------------------------------------------------------
    // Field widths
    // -------------------------------------------------------------------
    parameter int ID_W   = 4;
    parameter int ADDR_W = 16;
    // Must hold at least ID_W + ADDR_W bits
    parameter int DATA_W = 32;
    parameter int LEN_W  = 8;
    parameter int SIZE_W = 3;

    // -------------------------------------------------------------------
    // Enums
    // -------------------------------------------------------------------
    // AXI burst type encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // AXI response encoding, only the two codes this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Outstanding slot lifecycle
    typedef enum logic [1:0] {
        FREE  = 2'b00,
        FETCH = 2'b01,
        READY = 2'b10,
        SEND  = 2'b11
    } slot_state_e;

    // -------------------------------------------------------------------
    // Channel payloads
    // -------------------------------------------------------------------
    // One AR request
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        burst_e            burst;
    } ar_req_t;

    // One R beat
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } r_beat_t;

endpackage

//--- design/axi_rd_slave.sv
// AXI read-only slave top level
// Slot array, allocation and result arbiters, AR accept and R output select

`timescale 1ns/10ps

module axi_rd_slave #(
    parameter int OST_DEPTH     = 16,
    parameter int MAX_BURST_LEN = 8,
    parameter int FETCH_DLY     = 31
) (
    input  logic                clk,
    input  logic                rst_n,
    // AR channel
    input  logic                ar_valid,
    output logic                ar_ready,
    input  axi_rd_pkg::ar_req_t ar,
    // R channel
    output logic                r_valid,
    input  logic                r_ready,
    output axi_rd_pkg::r_beat_t r
);

    localparam int IDX_W = (OST_DEPTH > 1) ? $clog2(OST_DEPTH) : 1;

    // Per-slot status
    logic [OST_DEPTH-1:0] free_vec;
    logic [OST_DEPTH-1:0] send_vec;
    logic [OST_DEPTH-1:0] done_vec;
    axi_rd_pkg::r_beat_t  beat_arr [OST_DEPTH];

    // Allocation side
    logic [IDX_W-1:0]     alloc_idx;
    logic                 alloc_valid;
    logic                 ar_fire;

    // Result side
    logic [IDX_W-1:0]     res_idx;
    logic                 res_valid;
    logic                 grant_pulse;
    logic                 r_busy;
    logic [IDX_W-1:0]     r_idx;
    logic                 r_fire;
    logic                 burst_end;

    // -------------------------------------------------------------------
    // AR accept
    // -------------------------------------------------------------------
    rr_arbiter #(
        .N (OST_DEPTH)
    ) u_alloc_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (free_vec),
        .advance     (ar_fire),
        .grant_idx   (alloc_idx),
        .grant_valid (alloc_valid)
    );

    // Ready whenever some slot is free
    assign ar_ready = alloc_valid;
    assign ar_fire  = ar_valid && ar_ready;

    // -------------------------------------------------------------------
    // Result grant and lock
    // -------------------------------------------------------------------
    rr_arbiter #(
        .N (OST_DEPTH)
    ) u_result_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (send_vec),
        .advance     (grant_pulse),
        .grant_idx   (res_idx),
        .grant_valid (res_valid)
    );

    // A new burst is picked only while the R channel is idle
    assign grant_pulse = !r_busy && res_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_busy <= 1'b0;
            r_idx  <= '0;
        end else if (grant_pulse) begin
            r_busy <= 1'b1;
            r_idx  <= res_idx;
        end else if (burst_end) begin
            r_busy <= 1'b0;
        end
    end

    // -------------------------------------------------------------------
    // R output
    // -------------------------------------------------------------------
    assign r_valid   = r_busy && send_vec[r_idx];
    assign r         = beat_arr[r_idx];
    assign r_fire    = r_valid && r_ready;
    assign burst_end = r_fire && done_vec[r_idx];

    // -------------------------------------------------------------------
    // Slot array
    // -------------------------------------------------------------------
    for (genvar i = 0; i < OST_DEPTH; i++) begin : g_slot
        ost_slot #(
            .MAX_BURST_LEN (MAX_BURST_LEN),
            .FETCH_DLY     (FETCH_DLY)
        ) u_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .load       (ar_fire && (alloc_idx == IDX_W'(i))),
            .load_req   (ar),
            .grant      (grant_pulse && (res_idx == IDX_W'(i))),
            .beat_taken (r_fire && (r_idx == IDX_W'(i))),
            .free       (free_vec[i]),
            .send_req   (send_vec[i]),
            .done_req   (done_vec[i]),
            .beat       (beat_arr[i])
        );
    end

endmodule

//--- design/burst_addr_gen.sv
// Beat address generator
// FIXED, INCR and WRAP address of one beat of a stored AR request

`timescale 1ns/10ps

module burst_addr_gen (
    input  axi_rd_pkg::ar_req_t           req,
    input  logic [axi_rd_pkg::LEN_W-1:0]  beat_idx,
    output logic [axi_rd_pkg::ADDR_W-1:0] beat_addr
);

    localparam int AW = axi_rd_pkg::ADDR_W;

    // Bytes per beat and bytes per whole burst
    logic [AW-1:0] num_bytes;
    logic [AW-1:0] total_bytes;

    // Start address aligned down to the beat size
    logic [AW-1:0] aligned_addr;
    // Byte offset of beat_idx from the aligned start
    logic [AW-1:0] beat_step;

    // Wrap window
    logic [AW-1:0] wrap_boundary;
    logic [AW-1:0] wrap_offset;

    // -------------------------------------------------------------------
    // Common terms
    // -------------------------------------------------------------------
    assign num_bytes    = AW'(1) << req.size;
    assign total_bytes  = (AW'(req.len) + AW'(1)) << req.size;
    assign aligned_addr = req.addr & ~(num_bytes - AW'(1));
    assign beat_step    = AW'(beat_idx) << req.size;

    // WRAP lengths are 2, 4 or 8 beats, so total_bytes is a power of two
    // and the round-down and the modulo reduce to masks
    assign wrap_boundary = req.addr & ~(total_bytes - AW'(1));
    assign wrap_offset   = (aligned_addr - wrap_boundary + beat_step)
                           & (total_bytes - AW'(1));

    // -------------------------------------------------------------------
    // Address select
    // -------------------------------------------------------------------
    always_comb begin
        unique case (req.burst)
            axi_rd_pkg::FIXED: begin
                beat_addr = req.addr;
            end
            axi_rd_pkg::INCR: begin
                // First beat keeps the unaligned start
                if (beat_idx == '0) begin
                    beat_addr = req.addr;
                end else begin
                    beat_addr = aligned_addr + beat_step;
                end
            end
            axi_rd_pkg::WRAP: begin
                beat_addr = wrap_boundary + wrap_offset;
            end
            default: begin
                beat_addr = req.addr;
            end
        endcase
    end

endmodule

//--- design/ost_slot.sv
// One outstanding read slot
// Stored request, simulated fetch delay, beat buffer and slot FSM

`timescale 1ns/10ps

module ost_slot #(
    parameter int MAX_BURST_LEN = 8,
    parameter int FETCH_DLY     = 31
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  axi_rd_pkg::ar_req_t load_req,
    input  logic                grant,
    input  logic                beat_taken,
    output logic                free,
    output logic                send_req,
    output logic                done_req,
    output axi_rd_pkg::r_beat_t beat
);

    localparam int DW    = axi_rd_pkg::DATA_W;
    localparam int LW    = axi_rd_pkg::LEN_W;
    localparam int BUF_W = (MAX_BURST_LEN > 1) ? $clog2(MAX_BURST_LEN) : 1;
    localparam int DLY_W = $clog2(FETCH_DLY + 1);

    axi_rd_pkg::slot_state_e state;
    axi_rd_pkg::ar_req_t     req_q;

    // Fetch side
    logic [DLY_W-1:0]         fetch_cnt;
    logic [DLY_W-1:0]         fetch_dly;
    logic [LW-1:0]            fetch_idx;
    logic                     fetch_on;
    logic                     fetch_hit;
    logic [axi_rd_pkg::ADDR_W-1:0] fetch_addr;
    logic [DW-1:0]            fetch_data;

    // Beat buffer
    logic [DW-1:0]            buf_data [MAX_BURST_LEN];
    logic [MAX_BURST_LEN-1:0] fetched;

    // Send side
    logic [LW-1:0]            send_cnt;
    logic                     is_last;
    logic                     cur_fetched;

    // -------------------------------------------------------------------
    // Simulated memory fetch
    // -------------------------------------------------------------------
    // Lower IDs see a longer memory delay
    assign fetch_dly = DLY_W'(FETCH_DLY) - DLY_W'(req_q.id);
    assign fetch_hit = fetch_on && (fetch_cnt == DLY_W'(1));

    burst_addr_gen u_addr_gen (
        .req       (req_q),
        .beat_idx  (fetch_idx),
        .beat_addr (fetch_addr)
    );

    // ID next to the beat address, zero-extended
    assign fetch_data = DW'({req_q.id, fetch_addr});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_on  <= 1'b0;
            fetch_cnt <= '0;
            fetch_idx <= '0;
            fetched   <= '0;
        end else if (load) begin
            fetch_on  <= 1'b1;
            fetch_cnt <= DLY_W'(FETCH_DLY) - DLY_W'(load_req.id);
            fetch_idx <= '0;
            fetched   <= '0;
        end else if (fetch_hit) begin
            fetched[fetch_idx[BUF_W-1:0]] <= 1'b1;
            fetch_idx <= fetch_idx + LW'(1);
            fetch_cnt <= fetch_dly;
            if (fetch_idx == req_q.len) begin
                fetch_on <= 1'b0;
            end
        end else if (fetch_on) begin
            fetch_cnt <= fetch_cnt - DLY_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= load_req;
        end
        if (fetch_hit) begin
            buf_data[fetch_idx[BUF_W-1:0]] <= fetch_data;
        end
    end

    // -------------------------------------------------------------------
    // Slot FSM and send counter
    // -------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= axi_rd_pkg::FREE;
            send_cnt <= '0;
        end else begin
            unique case (state)
                axi_rd_pkg::FREE: begin
                    if (load) begin
                        state    <= axi_rd_pkg::FETCH;
                        send_cnt <= '0;
                    end
                end
                // Only beat 0 is outstanding here
                axi_rd_pkg::FETCH: begin
                    if (fetch_hit) begin
                        state <= axi_rd_pkg::READY;
                    end
                end
                axi_rd_pkg::READY: begin
                    if (grant) begin
                        state <= axi_rd_pkg::SEND;
                    end
                end
                axi_rd_pkg::SEND: begin
                    if (beat_taken) begin
                        send_cnt <= send_cnt + LW'(1);
                        if (is_last) begin
                            state <= axi_rd_pkg::FREE;
                        end
                    end
                end
                default: begin
                    state <= axi_rd_pkg::FREE;
                end
            endcase
        end
    end

    // -------------------------------------------------------------------
    // Status and current beat
    // -------------------------------------------------------------------
    assign is_last     = (send_cnt == req_q.len);
    assign cur_fetched = fetched[send_cnt[BUF_W-1:0]];

    assign free     = (state == axi_rd_pkg::FREE);
    // READY asks for the channel, SEND offers its next beat once fetched
    assign send_req = (state == axi_rd_pkg::READY) ||
                      ((state == axi_rd_pkg::SEND) && cur_fetched);
    assign done_req = (state != axi_rd_pkg::FREE) && is_last;

    always_comb begin
        beat.id   = req_q.id;
        beat.data = buf_data[send_cnt[BUF_W-1:0]];
        beat.last = is_last;
        if (is_last && (&req_q.id)) begin
            beat.resp = axi_rd_pkg::SLVERR;
        end else begin
            beat.resp = axi_rd_pkg::OKAY;
        end
    end

endmodule

//--- design/rr_arbiter.sv
// Round-robin arbiter
// Combinational grant from a request vector, rotating priority pointer

`timescale 1ns/10ps

module rr_arbiter #(
    parameter int N = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [N-1:0]                      req,
    input  logic                              advance,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] grant_idx,
    output logic                              grant_valid
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    // Highest priority index for the next pick
    logic [IDX_W-1:0] ptr;

    // -------------------------------------------------------------------
    // Grant search
    // -------------------------------------------------------------------
    // First set request at or after ptr, wrapping around
    always_comb begin
        int idx;
        grant_idx   = '0;
        grant_valid = 1'b0;
        for (int k = 0; k < N; k++) begin
            idx = (int'(ptr) + k) % N;
            if (!grant_valid && req[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = IDX_W'(idx);
            end
        end
    end

    // -------------------------------------------------------------------
    // Pointer update
    // -------------------------------------------------------------------
    // Move just past the index that was used this cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (advance && grant_valid) begin
            if (grant_idx == IDX_W'(N - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + IDX_W'(1);
            end
        end
    end

endmodule

//--- verif/axi_rd_slave_sva.sv
// AXI read slave protocol assertions
// R stability under stall, AR length limits, R idle after reset, plus bind

`timescale 1ns/10ps

module axi_rd_slave_sva #(
    parameter int MAX_BURST_LEN = 8
) (
    input logic                clk,
    input logic                rst_n,
    input logic                ar_valid,
    input axi_rd_pkg::ar_req_t ar,
    input logic                r_valid,
    input logic                r_ready,
    input axi_rd_pkg::r_beat_t r
);

    // Stalled beat holds until taken
    r_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("R channel changed while r_ready was low");

    // Length fits the buffer, WRAP only over 2, 4 or 8 beats
    ar_len_a: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid |-> (int'(ar.len) < MAX_BURST_LEN) &&
                     ((ar.burst != axi_rd_pkg::WRAP) || (ar.len == 8'd1) ||
                      (ar.len == 8'd3) || (ar.len == 8'd7)))
        else $error("AR request outside the burst length limits");

    r_idle_a: assert property (@(posedge clk) $rose(rst_n) |-> !r_valid)
        else $error("r_valid high in the first cycle after reset");

endmodule

bind axi_rd_slave axi_rd_slave_sva #(
    .MAX_BURST_LEN (MAX_BURST_LEN)
) sva_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar_valid (ar_valid),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r)
);

//--- verif/tb_axi_rd_slave.sv
// AXI read slave testbench
// Directed and random-stall tests checked against a per-ID model of the beats

`timescale 1ns/10ps

module tb_axi_rd_slave;

    localparam int AW         = axi_rd_pkg::ADDR_W;
    localparam int DW         = axi_rd_pkg::DATA_W;
    localparam int LW         = axi_rd_pkg::LEN_W;
    localparam int WAIT_LIMIT = 5000;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                ar_valid;
    logic                ar_ready;
    axi_rd_pkg::ar_req_t ar;
    logic                r_valid;
    logic                r_ready = 1'b0;
    axi_rd_pkg::r_beat_t r;

    // Expected beats, one queue per ID
    axi_rd_pkg::r_beat_t exp_q [2**axi_rd_pkg::ID_W][$];

    integer                      seed     = 32'h6e17;
    logic                        stall_en = 1'b0;
    logic                        aborted  = 1'b0;
    logic                        in_burst = 1'b0;
    logic [axi_rd_pkg::ID_W-1:0] cur_id   = '0;
    int                          errors;
    int                          beats_seen;
    int                          bursts_done;
    int                          tests_passed;
    int                          tests_failed;

    axi_rd_slave #(
        .OST_DEPTH (4)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Random back-pressure only while stalls are enabled
    always @(posedge clk) begin
        if (stall_en) begin
            r_ready <= ($random(seed) & 3) != 0;
        end else begin
            r_ready <= 1'b1;
        end
    end

    // -------------------------------------------------------------------
    // Reference model
    // -------------------------------------------------------------------
    function automatic logic [AW-1:0] expected_addr(input axi_rd_pkg::ar_req_t req,
                                                    input int k);
        int nb;
        int total;
        int start;
        int aligned;
        int boundary;
        nb       = 1 << req.size;
        total    = (int'(req.len) + 1) * nb;
        start    = int'(req.addr);
        aligned  = (start / nb) * nb;
        boundary = (start / total) * total;
        if (req.burst == axi_rd_pkg::FIXED || (req.burst == axi_rd_pkg::INCR && k == 0)) begin
            return req.addr;
        end else if (req.burst == axi_rd_pkg::WRAP) begin
            return AW'(boundary + ((aligned - boundary + k * nb) % total));
        end
        return AW'(aligned + k * nb);
    endfunction

    task automatic push_expected(input axi_rd_pkg::ar_req_t req);
        axi_rd_pkg::r_beat_t b;
        for (int k = 0; k <= int'(req.len); k++) begin
            b.id   = req.id;
            b.data = (DW'(req.id) << AW) | DW'(expected_addr(req, k));
            b.last = (k == int'(req.len));
            if (b.last && req.id == '1) begin
                b.resp = axi_rd_pkg::SLVERR;
            end else begin
                b.resp = axi_rd_pkg::OKAY;
            end
            exp_q[req.id].push_back(b);
        end
    endtask

    task automatic log_failure(input string msg);
        $display("FAIL @ %0t: %s", $time, msg);
        errors++;
    endtask

    // Every R transfer is compared with the head of its ID queue
    always @(posedge clk) begin
        axi_rd_pkg::r_beat_t exp_beat;
        if (rst_n && r_valid && r_ready) begin
            beats_seen++;
            assert (!in_burst || r.id == cur_id)
                else log_failure($sformatf("id %0d interleaved into burst of id %0d",
                                           r.id, cur_id));
            assert (exp_q[r.id].size() > 0)
                else log_failure($sformatf("unexpected beat for id %0d", r.id));
            if (exp_q[r.id].size() > 0) begin
                exp_beat = exp_q[r.id].pop_front();
                assert (r == exp_beat)
                    else log_failure($sformatf("id %0d got %h/%0d/%0b, expected %h/%0d/%0b",
                                               r.id, r.data, r.resp, r.last, exp_beat.data,
                                               exp_beat.resp, exp_beat.last));
            end
            in_burst = !r.last;
            cur_id   = r.id;
            if (r.last) begin
                bursts_done <= bursts_done + 1;
            end
        end
    end

    // -------------------------------------------------------------------
    // Stimulus helpers
    // -------------------------------------------------------------------
    task automatic send_ar(input logic [3:0] id, input logic [15:0] addr, input int len,
                           input int size, input axi_rd_pkg::burst_e burst);
        axi_rd_pkg::ar_req_t req;
        int                  cnt;
        if (aborted) begin
            return;
        end
        req.id    = id;
        req.addr  = addr;
        req.len   = LW'(len);
        req.size  = 3'(size);
        req.burst = burst;
        push_expected(req);
        @(posedge clk);
        ar_valid <= 1'b1;
        ar       <= req;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (!ar_ready && cnt < WAIT_LIMIT);
        ar_valid <= 1'b0;
        if (!ar_ready) begin
            $display("Timeout: the read request with id %0d was never accepted", id);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_bursts(input int target);
        int cnt;
        cnt = 0;
        while (bursts_done < target && cnt < WAIT_LIMIT && !aborted) begin
            @(posedge clk);
            cnt++;
        end
        if (bursts_done < target && !aborted) begin
            $display("Timeout: only %0d of %0d bursts came back", bursts_done, target);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic check_drained(input int id);
        assert (exp_q[id].size() == 0)
            else log_failure($sformatf("id %0d still expects %0d beats", id, exp_q[id].size()));
    endtask

    task automatic close_test(input int num, input string name, input int err_base);
        if (errors == err_base) begin
            tests_passed++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", num, name, errors - err_base);
        end
    endtask

    // -------------------------------------------------------------------
    // Test sequence
    // -------------------------------------------------------------------
    initial begin
        int err_base;
        int base;
        rst_n    <= 1'b0;
        ar_valid <= 1'b0;
        ar       <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        err_base = errors;
        @(posedge clk);
        assert (!r_valid && ar_ready)
            else log_failure($sformatf("after reset r_valid %0b ar_ready %0b", r_valid, ar_ready));
        close_test(1, "reset state", err_base);

        err_base = errors;
        base     = bursts_done;
        send_ar(4'd2, 16'h1006, 3, 2, axi_rd_pkg::INCR);
        wait_bursts(base + 1);
        check_drained(2);
        close_test(2, "INCR burst", err_base);

        err_base = errors;
        base     = bursts_done;
        send_ar(4'd3, 16'h2018, 3, 2, axi_rd_pkg::WRAP);
        send_ar(4'd5, 16'h3002, 2, 1, axi_rd_pkg::FIXED);
        wait_bursts(base + 2);
        check_drained(3);
        check_drained(5);
        close_test(3, "WRAP and FIXED bursts", err_base);

        err_base = errors;
        base     = bursts_done;
        send_ar(4'd15, 16'h4000, 3, 2, axi_rd_pkg::INCR);
        wait_bursts(base + 1);
        check_drained(15);
        close_test(4, "SLVERR on last beat", err_base);

        err_base = errors;
        base     = bursts_done;
        send_ar(4'd1, 16'h0100, 3, 2, axi_rd_pkg::INCR);
        send_ar(4'd6, 16'h0204, 3, 2, axi_rd_pkg::WRAP);
        send_ar(4'd9, 16'h0300, 3, 1, axi_rd_pkg::FIXED);
        send_ar(4'd12, 16'h0400, 3, 2, axi_rd_pkg::INCR);
        @(posedge clk);
        assert (!ar_ready) else log_failure("ar_ready high while every slot is busy");
        send_ar(4'd4, 16'h0500, 3, 2, axi_rd_pkg::INCR);
        assert (bursts_done > base) else log_failure("fifth request taken before a slot freed");
        wait_bursts(base + 5);
        close_test(5, "all slots busy", err_base);

        err_base = errors;
        base     = bursts_done;
        stall_en <= 1'b1;
        send_ar(4'd7, 16'h5001, 5, 0, axi_rd_pkg::INCR);
        send_ar(4'd8, 16'h603c, 7, 2, axi_rd_pkg::WRAP);
        send_ar(4'd10, 16'h7100, 3, 2, axi_rd_pkg::FIXED);
        send_ar(4'd11, 16'h8006, 1, 2, axi_rd_pkg::WRAP);
        send_ar(4'd13, 16'h9ffe, 6, 1, axi_rd_pkg::INCR);
        send_ar(4'd14, 16'hb010, 4, 3, axi_rd_pkg::INCR);
        wait_bursts(base + 6);
        stall_en <= 1'b0;
        for (int id = 0; id < 2**axi_rd_pkg::ID_W; id++) begin
            check_drained(id);
        end
        close_test(6, "random R stalls", err_base);

        $display("Tests ok %0d, with errors %0d, beats checked %0d, errors %0d",
                 tests_passed, tests_failed, beats_seen, errors);
        if (errors == 0 && !aborted) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
